// File: design/la_isa_pkg.sv
package la_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;     // Data word and PC
    typedef logic [31:0] instr_t;    // Raw instruction word
    typedef logic [4:0]  reg_idx_t;  // GPR index

    localparam int NUM_REGS = 32;

    // Supported ALU operations, NONE marks an opcode we do not decode
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_LUI  = 4'd7,
        ALU_NONE = 4'd15
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode fields
    ////////////////////////////////////////////////////////////////////////////

    // 3R format, opcode in [31:15], rk [14:10], rj [9:5], rd [4:0]
    localparam logic [16:0] OP17_ADD_W = 17'h00020;
    localparam logic [16:0] OP17_SUB_W = 17'h00022;
    localparam logic [16:0] OP17_SLT   = 17'h00024;
    localparam logic [16:0] OP17_SLTU  = 17'h00025;
    localparam logic [16:0] OP17_AND   = 17'h00029;
    localparam logic [16:0] OP17_OR    = 17'h0002a;
    localparam logic [16:0] OP17_XOR   = 17'h0002b;

    // 2RI12 format, si12 in [21:10]
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;

    // 1RI20 format, si20 in [24:5]
    localparam logic [6:0] OP7_LU12I_W = 7'h0a;

    // Field positions
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

    // Immediate widths
    localparam int SI12_W = 12;
    localparam int SI20_W = 20;

endpackage

// File: design/la_pipe_pkg.sv
package la_pipe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    // Decode -> dispatch
    typedef struct packed {
        logic                 valid;
        la_isa_pkg::word_t    pc;
        la_isa_pkg::alu_op_e  alu_op;
        la_isa_pkg::reg_idx_t rj;
        la_isa_pkg::reg_idx_t rk;
        la_isa_pkg::reg_idx_t rd;
        logic                 use_imm;  // src2 taken from imm
        la_isa_pkg::word_t    imm;      // Already extended or shifted
        logic                 rf_we;
    } decoded_t;

    // Dispatch -> execute, operands resolved
    typedef struct packed {
        logic                 valid;
        la_isa_pkg::word_t    pc;
        la_isa_pkg::alu_op_e  alu_op;
        la_isa_pkg::reg_idx_t rd;
        logic                 rf_we;
        la_isa_pkg::word_t    src1;
        la_isa_pkg::word_t    src2;
    } issue_t;

    // Execute -> writeback
    typedef struct packed {
        logic                 valid;
        la_isa_pkg::word_t    pc;
        la_isa_pkg::reg_idx_t rd;
        logic                 rf_we;
        la_isa_pkg::word_t    data;
    } result_t;

    // Forward source, we already qualified by valid
    typedef struct packed {
        logic                 we;
        la_isa_pkg::reg_idx_t rd;
        la_isa_pkg::word_t    data;
    } fwd_t;

endpackage

// File: design/la_regfile.sv
`timescale 1ns/10ps

module la_regfile (
    input  logic                 clk,
    input  la_isa_pkg::reg_idx_t raddr1_i,
    input  la_isa_pkg::reg_idx_t raddr2_i,
    input  logic                 we_i,
    input  la_isa_pkg::reg_idx_t waddr_i,
    input  la_isa_pkg::word_t    wdata_i,
    output la_isa_pkg::word_t    rdata1_o,
    output la_isa_pkg::word_t    rdata2_o
);

    // r0 has no storage
    la_isa_pkg::word_t regs [1:la_isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Plain read, same-cycle bypass lives in dispatch
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

    // Decode drops r0 writes long before they reach here
    a_no_r0_write : assert property (@(posedge clk)
        we_i |-> (waddr_i != '0));

endmodule

// File: design/la_decode.sv
`timescale 1ns/10ps

module la_decode #(
    parameter la_isa_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  instr_valid_i,
    input  la_isa_pkg::instr_t    instr_i,
    output la_pipe_pkg::decoded_t dec_o
);

    la_isa_pkg::word_t     pc_q;
    la_pipe_pkg::decoded_t dec_d;
    la_pipe_pkg::decoded_t dec_q;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;

    assign op17 = instr_i[31:15];
    assign op10 = instr_i[31:22];
    assign op7  = instr_i[31:25];

    // PC of the next accepted instruction
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_comb begin
        dec_d         = '0;
        dec_d.valid   = instr_valid_i;
        dec_d.pc      = pc_q;
        dec_d.rd      = instr_i[la_isa_pkg::RD_LSB +: 5];
        dec_d.rj      = instr_i[la_isa_pkg::RJ_LSB +: 5];
        dec_d.rk      = instr_i[la_isa_pkg::RK_LSB +: 5];
        dec_d.alu_op  = la_isa_pkg::ALU_NONE;

        if (op7 == la_isa_pkg::OP7_LU12I_W) begin
            dec_d.alu_op  = la_isa_pkg::ALU_LUI;
            dec_d.use_imm = 1'b1;
            dec_d.rj      = '0;  // Field belongs to si20
            dec_d.rk      = '0;
            dec_d.imm     = {instr_i[la_isa_pkg::RJ_LSB +: la_isa_pkg::SI20_W], 12'b0};
        end else if (op10 == la_isa_pkg::OP10_ADDI_W) begin
            dec_d.alu_op  = la_isa_pkg::ALU_ADD;
            dec_d.use_imm = 1'b1;
            dec_d.rk      = '0;
            dec_d.imm     = {{(32 - la_isa_pkg::SI12_W){instr_i[21]}}, instr_i[21:10]};
        end else begin
            case (op17)
                la_isa_pkg::OP17_ADD_W: dec_d.alu_op = la_isa_pkg::ALU_ADD;
                la_isa_pkg::OP17_SUB_W: dec_d.alu_op = la_isa_pkg::ALU_SUB;
                la_isa_pkg::OP17_SLT:   dec_d.alu_op = la_isa_pkg::ALU_SLT;
                la_isa_pkg::OP17_SLTU:  dec_d.alu_op = la_isa_pkg::ALU_SLTU;
                la_isa_pkg::OP17_AND:   dec_d.alu_op = la_isa_pkg::ALU_AND;
                la_isa_pkg::OP17_OR:    dec_d.alu_op = la_isa_pkg::ALU_OR;
                la_isa_pkg::OP17_XOR:   dec_d.alu_op = la_isa_pkg::ALU_XOR;
                default:                dec_d.alu_op = la_isa_pkg::ALU_NONE;
            endcase
        end

        // r0 and unknown opcodes pass through silently
        dec_d.rf_we = instr_valid_i && (dec_d.alu_op != la_isa_pkg::ALU_NONE)
                      && (dec_d.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

    // Catches a misaligned RESET_PC
    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

// File: design/la_dispatch.sv
`timescale 1ns/10ps

module la_dispatch (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  la_pipe_pkg::decoded_t dec_i,
    input  la_isa_pkg::word_t     rf_rdata1_i,
    input  la_isa_pkg::word_t     rf_rdata2_i,
    input  la_pipe_pkg::fwd_t     ex_fwd_i,
    input  la_pipe_pkg::fwd_t     wb_fwd_i,
    output la_isa_pkg::reg_idx_t  rf_raddr1_o,
    output la_isa_pkg::reg_idx_t  rf_raddr2_o,
    output la_pipe_pkg::issue_t   iss_o
);

    la_isa_pkg::word_t   src1;
    la_isa_pkg::word_t   src2_reg;
    la_pipe_pkg::issue_t iss_d;
    la_pipe_pkg::issue_t iss_q;

    ////////////////////////////////////////////////////////////////////////////
    // Operand read and forwarding
    ////////////////////////////////////////////////////////////////////////////

    // Register file is read straight from the decode register
    assign rf_raddr1_o = dec_i.rj;
    assign rf_raddr2_o = dec_i.rk;

    // Youngest producer wins, r0 is hardwired
    function automatic la_isa_pkg::word_t pick_operand(
        input la_isa_pkg::reg_idx_t idx,
        input la_isa_pkg::word_t    rf_data,
        input la_pipe_pkg::fwd_t    ex_fwd,
        input la_pipe_pkg::fwd_t    wb_fwd
    );
        la_isa_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_fwd.we && (ex_fwd.rd == idx)) begin
            val = ex_fwd.data;  // One ahead, still in execute
        end else if (wb_fwd.we && (wb_fwd.rd == idx)) begin
            val = wb_fwd.data;  // Two ahead, written this cycle
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign src1     = pick_operand(dec_i.rj, rf_rdata1_i, ex_fwd_i, wb_fwd_i);
    assign src2_reg = pick_operand(dec_i.rk, rf_rdata2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        iss_d.valid  = dec_i.valid;
        iss_d.pc     = dec_i.pc;
        iss_d.alu_op = dec_i.alu_op;
        iss_d.rd     = dec_i.rd;
        iss_d.rf_we  = dec_i.rf_we;
        iss_d.src1   = src1;
        iss_d.src2   = dec_i.use_imm ? dec_i.imm : src2_reg;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            iss_q <= '0;
        end else begin
            iss_q <= iss_d;
        end
    end

    assign iss_o = iss_q;

endmodule

// File: design/la_execute.sv
`timescale 1ns/10ps

module la_execute (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  la_pipe_pkg::issue_t  iss_i,
    output la_pipe_pkg::result_t res_o,
    output la_pipe_pkg::fwd_t    ex_fwd_o
);

    la_isa_pkg::word_t    alu_out;
    la_pipe_pkg::result_t res_q;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (iss_i.alu_op)
            la_isa_pkg::ALU_ADD:  alu_out = iss_i.src1 + iss_i.src2;  // Wraps
            la_isa_pkg::ALU_SUB:  alu_out = iss_i.src1 - iss_i.src2;
            la_isa_pkg::ALU_SLT:  alu_out = {31'b0, $signed(iss_i.src1) < $signed(iss_i.src2)};
            la_isa_pkg::ALU_SLTU: alu_out = {31'b0, iss_i.src1 < iss_i.src2};
            la_isa_pkg::ALU_AND:  alu_out = iss_i.src1 & iss_i.src2;
            la_isa_pkg::ALU_OR:   alu_out = iss_i.src1 | iss_i.src2;
            la_isa_pkg::ALU_XOR:  alu_out = iss_i.src1 ^ iss_i.src2;
            la_isa_pkg::ALU_LUI:  alu_out = iss_i.src2;  // Imm already shifted
            default:              alu_out = '0;
        endcase
    end

    // Result of the instruction sitting in execute right now
    assign ex_fwd_o.we   = iss_i.valid && iss_i.rf_we;
    assign ex_fwd_o.rd   = iss_i.rd;
    assign ex_fwd_o.data = alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_q <= '0;
        end else begin
            res_q.valid <= iss_i.valid;
            res_q.pc    <= iss_i.pc;
            res_q.rd    <= iss_i.rd;
            res_q.rf_we <= iss_i.rf_we;
            res_q.data  <= alu_out;
        end
    end

    assign res_o = res_q;

    // Decode never lets an unknown opcode request a write
    a_none_no_write : assert property (@(posedge clk) disable iff (!rst_n_i)
        iss_i.valid |-> !((iss_i.alu_op == la_isa_pkg::ALU_NONE) && iss_i.rf_we));

endmodule

// File: design/la_writeback.sv
`timescale 1ns/10ps

module la_writeback (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  la_pipe_pkg::result_t res_i,
    output logic                 rf_we_o,
    output la_isa_pkg::reg_idx_t rf_waddr_o,
    output la_isa_pkg::word_t    rf_wdata_o,
    output la_pipe_pkg::fwd_t    wb_fwd_o,
    output la_isa_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]           debug_wb_rf_wen_o,
    output la_isa_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output la_isa_pkg::word_t    debug_wb_rf_wdata_o
);

    logic wr_en;

    assign wr_en = res_i.valid && res_i.rf_we;

    // Regfile write and the matching bypass
    assign rf_we_o    = wr_en;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = res_i.data;
    assign wb_fwd_o   = '{we: wr_en, rd: res_i.rd, data: res_i.data};

    ////////////////////////////////////////////////////////////////////////////
    // Debug commit port, one cycle after the regfile write is presented
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            debug_wb_rf_wen_o <= 4'b0000;
        end else begin
            debug_wb_rf_wen_o <= {4{wr_en}};  // Full word strobe
        end
    end

    always_ff @(posedge clk) begin
        if (res_i.valid) begin
            debug_wb_pc_o       <= res_i.pc;
            debug_wb_rf_wnum_o  <= res_i.rd;
            debug_wb_rf_wdata_o <= res_i.data;
        end
    end

endmodule

// File: design/la_core_top.sv
`timescale 1ns/10ps

module la_core_top #(
    parameter la_isa_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  la_isa_pkg::instr_t   instr_i,
    output la_isa_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]           debug_wb_rf_wen_o,
    output la_isa_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output la_isa_pkg::word_t    debug_wb_rf_wdata_o
);

    // Stage bundles
    la_pipe_pkg::decoded_t dec;
    la_pipe_pkg::issue_t   iss;
    la_pipe_pkg::result_t  res;

    // Bypass sources
    la_pipe_pkg::fwd_t ex_fwd;
    la_pipe_pkg::fwd_t wb_fwd;

    // Regfile ports
    la_isa_pkg::reg_idx_t rf_raddr1, rf_raddr2;
    la_isa_pkg::word_t    rf_rdata1, rf_rdata2;
    logic                 rf_we;
    la_isa_pkg::reg_idx_t rf_waddr;
    la_isa_pkg::word_t    rf_wdata;

    la_decode #(
        .RESET_PC(RESET_PC)
    ) u_decode (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .dec_o(dec)
    );

    la_dispatch u_dispatch (
        .clk(clk), .rst_n_i(rst_n_i), .dec_i(dec),
        .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
        .ex_fwd_i(ex_fwd), .wb_fwd_i(wb_fwd),
        .rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
        .iss_o(iss)
    );

    la_regfile u_regfile (
        .clk(clk), .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    la_execute u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .iss_i(iss),
        .res_o(res), .ex_fwd_o(ex_fwd)
    );

    la_writeback u_writeback (
        .clk(clk), .rst_n_i(rst_n_i), .res_i(res),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .wb_fwd_o(wb_fwd),
        .debug_wb_pc_o(debug_wb_pc_o), .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o), .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

// File: verif/la_core_ref.svh
`ifndef LA_CORE_REF_SVH
`define LA_CORE_REF_SVH

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings of the supported subset
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    typedef logic [31:0][31:0] model_regs_t;  // Word n is rn

    // What one instruction does to the register file
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } ref_commit_t;

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi_w(input logic [4:0] rd, input logic [4:0] rj,
                                               input logic [11:0] si12);
        return {OPC_ADDI_W, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i_w(input logic [4:0] rd, input logic [19:0] si20);
        return {OPC_LU12I_W, si20, rd};
    endfunction

    // Executes one word on the model, r0 stays zero
    function automatic ref_commit_t ref_exec(input logic [31:0] instr, inout model_regs_t regs);
        ref_commit_t c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        known;
        a     = regs[instr[9:5]];
        b     = regs[instr[14:10]];
        res   = '0;
        known = 1'b1;
        if (instr[31:25] == OPC_LU12I_W) begin
            res = {instr[24:5], 12'h000};
        end else if (instr[31:22] == OPC_ADDI_W) begin
            res = a + {{20{instr[21]}}, instr[21:10]};
        end else begin
            case (instr[31:15])
                OPC_ADD_W: res = a + b;
                OPC_SUB_W: res = a - b;
                OPC_SLT:   res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
                OPC_SLTU:  res = {31'b0, a < b};
                OPC_AND:   res = a & b;
                OPC_OR:    res = a | b;
                OPC_XOR:   res = a ^ b;
                default:   known = 1'b0;
            endcase
        end
        c.we   = known && (instr[4:0] != 5'd0);
        c.rd   = instr[4:0];
        c.data = res;
        if (c.we) begin
            regs[c.rd] = res;
        end
        regs[0] = '0;
        return c;
    endfunction

`endif

// File: verif/la_core_tb.sv
`timescale 1ns/10ps

module la_core_tb;

    localparam logic [31:0] RESET_PC        = 32'h1c000000;
    localparam logic [31:0] SEED            = 32'hb5a2198f;
    localparam int          RST_CYCLES      = 3;
    localparam int          TEST_LEN        = 200;  // Random instructions
    localparam int          MAX_GAP         = 3;
    localparam int          DIRECTED_CYCLES = 140;  // Bound on all cycles outside the random run
    localparam int          TIMEOUT_CYCLES  = RST_CYCLES + DIRECTED_CYCLES
                                              + TEST_LEN * (MAX_GAP + 1) + 20;

    `include "la_core_ref.svh"

    // One commit the DUT owes us
    typedef struct packed {
        logic [2:0]  test_id;
        logic [31:0] cyc;      // Cycle count at which it must show
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_commit_t;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    model_regs_t model;
    exp_commit_t exp_q[$];
    int unsigned cyc      = 0;
    int unsigned sent     = 0;   // Accepted instructions, gives the PC
    logic [2:0]  cur_test = 3'd0;

    la_core_top #(
        .RESET_PC(RESET_PC)
    ) DUT (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .debug_wb_pc_o(debug_wb_pc_o), .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o), .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_idle";
            3'd1:    return "alu_directed";
            3'd2:    return "dependences";
            3'd3:    return "fixed_latency";
            3'd4:    return "r0_unknown";
            default: return "random_program";
        endcase
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_mismatch(input logic [2:0] id, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        stop_with_failure($sformatf("[ERROR] %s %s: expected 0x%08h actual 0x%08h",
                                    test_name(id), field, expected, actual));
    endtask

    // Model first, then one strobe on the falling edge
    task automatic send_instr(input logic [31:0] word);
        ref_commit_t c;
        c = ref_exec(word, model);
        if (c.we) begin
            exp_q.push_back('{test_id: cur_test, cyc: cyc + 4, pc: RESET_PC + 4 * sent,
                              rd: c.rd, data: c.data});
        end
        instr_i       = word;
        instr_valid_i = 1'b1;
        @(negedge clk);
        instr_valid_i = 1'b0;
        sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        rd = 5'($urandom_range(0, 31));
        rj = 5'($urandom_range(0, 31));
        rk = 5'($urandom_range(0, 31));
        case ($urandom_range(0, 8))
            0:       return enc_3r(OPC_ADD_W, rd, rj, rk);
            1:       return enc_3r(OPC_SUB_W, rd, rj, rk);
            2:       return enc_3r(OPC_SLT, rd, rj, rk);
            3:       return enc_3r(OPC_SLTU, rd, rj, rk);
            4:       return enc_3r(OPC_AND, rd, rj, rk);
            5:       return enc_3r(OPC_OR, rd, rj, rk);
            6:       return enc_3r(OPC_XOR, rd, rj, rk);
            7:       return enc_addi_w(rd, rj, 12'($urandom));
            default: return enc_lu12i_w(rd, 20'($urandom));
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Cycle count, timeout and commit checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cyc <= cyc + 1;
        assert (cyc < TIMEOUT_CYCLES)
            else stop_with_failure("Timeout, the run did not finish within the cycle limit");
    end

    // Debug port is stable at the falling edge
    always @(negedge clk) begin
        exp_commit_t e;
        if (debug_wb_rf_wen_o !== 4'b0000) begin
            assert (exp_q.size() != 0)
                else stop_with_failure("The DUT committed a register write that was not expected");
            e = exp_q.pop_front();
            assert (debug_wb_rf_wen_o == 4'b1111)
                else report_mismatch(e.test_id, "wen", 32'hf, 32'(debug_wb_rf_wen_o));
            assert (e.cyc == cyc) else report_mismatch(e.test_id, "commit cycle", e.cyc, cyc);
            assert (debug_wb_pc_o == e.pc)
                else report_mismatch(e.test_id, "pc", e.pc, debug_wb_pc_o);
            assert (debug_wb_rf_wnum_o == e.rd)
                else report_mismatch(e.test_id, "wnum", 32'(e.rd), 32'(debug_wb_rf_wnum_o));
            assert (debug_wb_rf_wdata_o == e.data)
                else report_mismatch(e.test_id, "wdata", e.data, debug_wb_rf_wdata_o);
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].cyc > cyc)
                else stop_with_failure($sformatf("An expected commit of %s did not appear",
                                                 test_name(exp_q[0].test_id)));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int         i;
        int         d;
        logic [4:0] r;
        logic [16:0] op;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        model         = '0;
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        idle_cycles(4);  // Any commit here is flagged by the checker

        cur_test = 3'd1;
        send_instr(enc_lu12i_w(5'd1, 20'h80000));
        send_instr(enc_addi_w(5'd1, 5'd1, 12'h005));   // r1 negative
        send_instr(enc_lu12i_w(5'd2, 20'h12345));
        send_instr(enc_addi_w(5'd2, 5'd2, 12'h678));
        send_instr(enc_addi_w(5'd3, 5'd0, 12'hfff));   // -1
        send_instr(enc_addi_w(5'd4, 5'd0, 12'h7ff));
        send_instr(enc_3r(OPC_ADD_W, 5'd5, 5'd1, 5'd2));
        send_instr(enc_3r(OPC_SUB_W, 5'd6, 5'd2, 5'd1));
        send_instr(enc_3r(OPC_SLT, 5'd7, 5'd1, 5'd2));  // Signed and unsigned disagree
        send_instr(enc_3r(OPC_SLTU, 5'd8, 5'd1, 5'd2));
        send_instr(enc_3r(OPC_SLT, 5'd9, 5'd3, 5'd4));
        send_instr(enc_3r(OPC_SLTU, 5'd10, 5'd3, 5'd4));
        send_instr(enc_3r(OPC_AND, 5'd11, 5'd1, 5'd2));
        send_instr(enc_3r(OPC_OR, 5'd12, 5'd1, 5'd3));
        send_instr(enc_3r(OPC_XOR, 5'd13, 5'd2, 5'd4));
        send_instr(enc_3r(OPC_ADD_W, 5'd14, 5'd3, 5'd4));  // Wraps
        idle_cycles(2);

        // Distance 1, 2 and 3 hit ex_fwd, wb_fwd and the regfile
        cur_test = 3'd2;
        send_instr(enc_addi_w(5'd20, 5'd0, 12'h011));
        send_instr(enc_addi_w(5'd21, 5'd0, 12'h9a2));
        send_instr(enc_lu12i_w(5'd22, 20'hc0ffe));
        for (d = 1; d <= 3; d++) begin
            for (i = 0; i < 9; i++) begin
                r  = 5'(20 + i % d);
                op = (i % 3 == 0) ? OPC_ADD_W : ((i % 3 == 1) ? OPC_XOR : OPC_SUB_W);
                if (i % 2 == 1) begin
                    send_instr(enc_3r(op, r, 5'd2, r));  // Dependence on rk
                end else begin
                    send_instr(enc_3r(op, r, r, 5'd2));
                end
            end
            idle_cycles(2);
        end

        cur_test = 3'd3;
        idle_cycles(6);
        send_instr(enc_addi_w(5'd23, 5'd0, 12'h123));
        idle_cycles(6);

        cur_test = 3'd4;
        send_instr(enc_addi_w(5'd0, 5'd1, 12'h123));       // Write to r0 dropped
        send_instr(32'hffffffff);                          // Unknown, rd field is r31
        send_instr(enc_3r(17'h00021, 5'd9, 5'd1, 5'd2));   // Unsupported 3R slot
        send_instr(enc_3r(OPC_OR, 5'd24, 5'd0, 5'd0));
        send_instr(enc_3r(OPC_ADD_W, 5'd25, 5'd9, 5'd0));  // r9 kept its value
        idle_cycles(2);

        cur_test = 3'd5;
        for (i = 1; i < 32; i++) begin
            send_instr(enc_addi_w(5'(i), 5'd0, 12'($urandom)));
        end
        for (i = 0; i < TEST_LEN; i++) begin
            send_instr(random_instr());
            idle_cycles($urandom_range(0, MAX_GAP));
        end

        idle_cycles(8);  // Longer than the pipeline
        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d expected commits never appeared", exp_q.size()));
        end
    end

endmodule

// File: la_core.f
+incdir+verif
design/la_isa_pkg.sv
design/la_pipe_pkg.sv
design/la_regfile.sv
design/la_decode.sv
design/la_dispatch.sv
design/la_execute.sv
design/la_writeback.sv
design/la_core_top.sv
verif/la_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the la_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module la_core_tb --Mdir build -f la_core.f

./build/Vla_core_tb
